//--- hdl/ex_op_pkg.sv
package ex_op_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SPR_IDX_W  = 4;   // Caps each SPR bank at 16 entries

  typedef logic [XLEN-1:0] word_t;

  //////////////////////////////////////////////////////////////////////
  // Execute operations
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    OP_NOP    = 4'd0,
    OP_ADD    = 4'd1,
    OP_SUB    = 4'd2,
    OP_SLT    = 4'd3,
    OP_BEQ    = 4'd4,
    OP_BLT    = 4'd5,
    OP_DOT8   = 4'd6,    // Register operands, byte lanes
    OP_DOT16  = 4'd7,    // Register operands, halfword lanes
    OP_LOAD   = 4'd8,
    OP_SDOT8  = 4'd9,    // Load-compute, SPR operands
    OP_SDOT16 = 4'd10
  } ex_op_e;

  // Signed SIMD lanes
  typedef logic signed [7:0]  lane8_t;
  typedef logic signed [15:0] lane16_t;

  // One data word read either as four bytes or as two halfwords
  typedef union packed {
    lane8_t  [3:0] b;    // DOT8 view
    lane16_t [1:0] h;    // DOT16 view
  } simd_word_u;

endpackage

//--- hdl/ex_port_pkg.sv
package ex_port_pkg;

  import ex_op_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Bundles between ID, EX and WB
  //////////////////////////////////////////////////////////////////////

  // SPR write target
  typedef struct packed {
    logic                 en;
    logic                 is_act;   // Activation bank when set, else weight bank
    logic [SPR_IDX_W-1:0] idx;
  } spr_wr_t;

  // Instruction entering EX
  typedef struct packed {
    ex_op_e                op;
    word_t                 operand_a;
    word_t                 operand_b;
    word_t                 operand_c;   // Accumulator or jump target
    logic [REG_ADDR_W-1:0] waddr;
    spr_wr_t               spr_dst;     // SPR loaded by this instruction
    logic [SPR_IDX_W-1:0]  w_idx;       // Weight SPR read by SDOT
    logic [SPR_IDX_W-1:0]  a_idx;       // Activation SPR read by SDOT
  } ex_req_t;

  // Register-file write, used by the forwarding and load ports
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    word_t                 wdata;
  } rf_wr_t;

endpackage

//--- hdl/ex_alu.sv
module ex_alu import ex_op_pkg::*; (
  input  ex_op_e op_i,
  input  word_t  operand_a_i,
  input  word_t  operand_b_i,
  output word_t  result_o,
  output logic   cmp_o
);

  word_t sum;
  word_t diff;
  logic  lt_signed;
  logic  eq;

  assign sum       = operand_a_i + operand_b_i;
  assign diff      = operand_a_i - operand_b_i;
  assign lt_signed = $signed(operand_a_i) < $signed(operand_b_i);
  assign eq        = (operand_a_i == operand_b_i);

  // Arithmetic result
  always_comb begin
    case (op_i)
      OP_ADD:  result_o = sum;
      OP_SUB:  result_o = diff;
      OP_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      default: result_o = '0;
    endcase
  end

  // Branch compare, low for every other op
  always_comb begin
    case (op_i)
      OP_BEQ:  cmp_o = eq;
      OP_BLT:  cmp_o = lt_signed;
      default: cmp_o = 1'b0;
    endcase
  end

endmodule

//--- hdl/ex_dot_unit.sv
module ex_dot_unit import ex_op_pkg::*; (
  input  ex_op_e op_i,
  input  word_t  operand_a_i,
  input  word_t  operand_b_i,
  input  word_t  operand_c_i,
  input  word_t  wspr_i,
  input  word_t  aspr_i,
  output word_t  result_o
);

  simd_word_u         src_a;
  simd_word_u         src_b;
  logic               use_spr;
  logic               half_mode;
  logic signed [15:0] prod8  [4];
  logic signed [31:0] prod16 [2];
  logic signed [31:0] acc;

  assign use_spr   = (op_i == OP_SDOT8) || (op_i == OP_SDOT16);
  assign half_mode = (op_i == OP_DOT16) || (op_i == OP_SDOT16);

  //////////////////////////////////////////////////////////////////////
  // Operand selection
  //////////////////////////////////////////////////////////////////////

  // Load-compute dots take weights and activations from the SPRs
  assign src_a = use_spr ? wspr_i : operand_a_i;
  assign src_b = use_spr ? aspr_i : operand_b_i;

  //////////////////////////////////////////////////////////////////////
  // Lane products and accumulation
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      prod8[i] = $signed(src_a.b[i]) * $signed(src_b.b[i]);
    end
    for (int i = 0; i < 2; i++) begin
      prod16[i] = $signed(src_a.h[i]) * $signed(src_b.h[i]);
    end
  end

  always_comb begin
    acc = $signed(operand_c_i);   // Accumulator operand
    if (half_mode) begin
      for (int i = 0; i < 2; i++) begin
        acc = acc + prod16[i];
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        acc = acc + prod8[i];     // Sign extended to 32 bits
      end
    end
  end

  // Sum wraps at 32 bits
  assign result_o = word_t'(acc);

endmodule

//--- hdl/ex_spr_file.sv
module ex_spr_file import ex_op_pkg::*; import ex_port_pkg::*; #(
  parameter int NUM_WSPR = 4,
  parameter int NUM_ASPR = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [SPR_IDX_W-1:0] w_idx_i,
  input  logic [SPR_IDX_W-1:0] a_idx_i,
  input  spr_wr_t              wr_i,
  input  word_t                lsu_rdata_i,
  output word_t                wspr_o,
  output word_t                aspr_o
);

  word_t [NUM_WSPR-1:0] wspr_q;   // Weight bank
  word_t [NUM_ASPR-1:0] aspr_q;   // Activation bank

  // Read ports, index beyond the bank reads zero
  always_comb begin
    wspr_o = '0;
    aspr_o = '0;
    for (int i = 0; i < NUM_WSPR; i++) begin
      if (w_idx_i == SPR_IDX_W'(i)) wspr_o = wspr_q[i];
    end
    for (int i = 0; i < NUM_ASPR; i++) begin
      if (a_idx_i == SPR_IDX_W'(i)) aspr_o = aspr_q[i];
    end
  end

  // Load data lands in the bank and entry named by the WB item
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wspr_q <= '0;
      aspr_q <= '0;
    end else if (wr_i.en) begin
      for (int i = 0; i < NUM_WSPR; i++) begin
        if (!wr_i.is_act && wr_i.idx == SPR_IDX_W'(i)) wspr_q[i] <= lsu_rdata_i;
      end
      for (int i = 0; i < NUM_ASPR; i++) begin
        if (wr_i.is_act && wr_i.idx == SPR_IDX_W'(i)) aspr_q[i] <= lsu_rdata_i;
      end
    end
  end

endmodule

//--- hdl/ex_fwd_ctrl.sv
module ex_fwd_ctrl import ex_op_pkg::*; import ex_port_pkg::*; (
  input  ex_req_t req_i,
  input  logic    id_valid_i,
  input  logic    wb_ready_i,
  input  word_t   alu_result_i,
  input  word_t   dot_result_i,
  input  logic    alu_cmp_i,
  output rf_wr_t  fwd_o,
  output logic    ex_ready_o,
  output logic    ex_valid_o,
  output logic    branch_decision_o,
  output word_t   jump_target_o
);

  logic is_alu;
  logic is_rdot;
  logic is_branch;
  logic is_nop;
  logic accept;

  //////////////////////////////////////////////////////////////////////
  // Op classes
  //////////////////////////////////////////////////////////////////////

  assign is_alu    = (req_i.op == OP_ADD) || (req_i.op == OP_SUB) || (req_i.op == OP_SLT);
  assign is_rdot   = (req_i.op == OP_DOT8) || (req_i.op == OP_DOT16);
  assign is_branch = (req_i.op == OP_BEQ) || (req_i.op == OP_BLT);
  assign is_nop    = (req_i.op == OP_NOP);

  //////////////////////////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////////////////////////

  // Branches resolve here, so WB back-pressure never stalls them
  assign ex_ready_o = wb_ready_i | (id_valid_i & is_branch);
  assign accept     = id_valid_i & ex_ready_o;

  // Everything except branches and bubbles moves on to WB
  assign ex_valid_o = id_valid_i & ~is_branch & ~is_nop & wb_ready_i;

  // Forwarding port, written in the acceptance cycle
  always_comb begin
    fwd_o.we    = accept & (is_alu | is_rdot);
    fwd_o.waddr = req_i.waddr;
    fwd_o.wdata = is_rdot ? dot_result_i : alu_result_i;
  end

  // Branch outcome
  assign branch_decision_o = id_valid_i & is_branch & alu_cmp_i;
  assign jump_target_o     = req_i.operand_c;

endmodule

//--- hdl/ex_wb_reg.sv
module ex_wb_reg import ex_op_pkg::*; import ex_port_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  ex_req_t req_i,
  input  logic    ex_valid_i,
  input  logic    wb_ready_i,
  input  word_t   dot_result_i,
  input  word_t   lsu_rdata_i,
  output rf_wr_t  wb_o,
  output spr_wr_t spr_wr_o
);

  logic                  is_load;
  logic                  is_sdot;
  logic                  we_d;
  spr_wr_t               spr_d;
  logic                  we_q;      // GPR write pending in WB
  logic                  sdot_q;    // Write data comes from the dot result
  logic [REG_ADDR_W-1:0] waddr_q;
  spr_wr_t               spr_q;
  word_t                 dot_q;

  assign is_load = (req_i.op == OP_LOAD);
  assign is_sdot = (req_i.op == OP_SDOT8) || (req_i.op == OP_SDOT16);

  // A load goes either to a GPR or to an SPR; an SDOT always writes its GPR
  assign we_d = (is_load & ~req_i.spr_dst.en) | is_sdot;

  always_comb begin
    spr_d    = req_i.spr_dst;
    spr_d.en = req_i.spr_dst.en & (is_load | is_sdot);
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      sdot_q  <= 1'b0;
      waddr_q <= '0;
      spr_q   <= '0;
      dot_q   <= '0;
    end else if (ex_valid_i) begin   // Old item retires in the same edge
      we_q    <= we_d;
      sdot_q  <= is_sdot;
      waddr_q <= req_i.waddr;
      spr_q   <= spr_d;
      dot_q   <= dot_result_i;
    end else if (wb_ready_i) begin
      // Retired with nothing behind it
      we_q     <= 1'b0;
      spr_q.en <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Load write port and SPR write
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wb_o.we    = we_q;
    wb_o.waddr = waddr_q;
    wb_o.wdata = sdot_q ? dot_q : lsu_rdata_i;
  end

  always_comb begin
    spr_wr_o    = spr_q;
    spr_wr_o.en = spr_q.en & wb_ready_i;   // Only at the retiring edge
  end

endmodule

//--- hdl/ex_stage.sv
module ex_stage import ex_op_pkg::*; import ex_port_pkg::*; #(
  parameter int NUM_WSPR = 4,
  parameter int NUM_ASPR = 2
) (
  input  logic    clk,
  input  logic    rst_n,

  // From ID
  input  ex_req_t req_i,
  input  logic    id_valid_i,
  output logic    ex_ready_o,

  // To WB
  output logic    ex_valid_o,
  input  logic    wb_ready_i,
  input  word_t   lsu_rdata_i,   // Load data of the item in WB

  // Write ports
  output rf_wr_t  fwd_o,
  output rf_wr_t  wb_o,

  // To IF
  output logic    branch_decision_o,
  output word_t   jump_target_o
);

  word_t   alu_result;
  logic    alu_cmp;
  word_t   dot_result;
  word_t   wspr;
  word_t   aspr;
  spr_wr_t spr_wr;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .op_i        (req_i.op),
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .result_o    (alu_result),
    .cmp_o       (alu_cmp)
  );

  ex_dot_unit u_dot (
    .op_i        (req_i.op),
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .operand_c_i (req_i.operand_c),
    .wspr_i      (wspr),
    .aspr_i      (aspr),
    .result_o    (dot_result)
  );

  ex_spr_file #(
    .NUM_WSPR (NUM_WSPR),
    .NUM_ASPR (NUM_ASPR)
  ) u_spr (
    .clk         (clk),
    .rst_n       (rst_n),
    .w_idx_i     (req_i.w_idx),
    .a_idx_i     (req_i.a_idx),
    .wr_i        (spr_wr),
    .lsu_rdata_i (lsu_rdata_i),
    .wspr_o      (wspr),
    .aspr_o      (aspr)
  );

  //////////////////////////////////////////////////////////////////////
  // Control and write-back
  //////////////////////////////////////////////////////////////////////

  ex_fwd_ctrl u_fwd (
    .req_i             (req_i),
    .id_valid_i        (id_valid_i),
    .wb_ready_i        (wb_ready_i),
    .alu_result_i      (alu_result),
    .dot_result_i      (dot_result),
    .alu_cmp_i         (alu_cmp),
    .fwd_o             (fwd_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o)
  );

  ex_wb_reg u_wb (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .ex_valid_i   (ex_valid_o),
    .wb_ready_i   (wb_ready_i),
    .dot_result_i (dot_result),
    .lsu_rdata_i  (lsu_rdata_i),
    .wb_o         (wb_o),
    .spr_wr_o     (spr_wr)
  );

endmodule

//--- verif/tb_ex_stage.sv
module tb_ex_stage import ex_op_pkg::*; import ex_port_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    CLK_PERIOD = 10;
  localparam int    RST_CYCLES = 10;
  localparam string STIM_FILE  = "verif/ex_stimulus.txt";

  // Model of the single WB slot
  typedef struct packed {
    int     test;
    logic   finishes;   // Test completes when the item retires
    rf_wr_t exp;
    word_t  ldata;
  } wb_item_t;

  logic     clk = 1'b0;
  logic     rst_n;
  ex_req_t  req_i;
  logic     id_valid_i, wb_ready_i;
  word_t    lsu_rdata_i;
  logic     ex_ready_o, ex_valid_o, branch_decision_o;
  rf_wr_t   fwd_o, wb_o;
  word_t    jump_target_o;

  ex_req_t  req_tab [$];
  word_t    ldata_tab [$];
  word_t    exp_tab [$];
  string    tag_tab [$];
  wb_item_t wb_q [$];

  logic [31:0] rnd = 32'h6dae_7729;
  bit          stim_loaded;
  bit          req_ok, front_ok, rst_ok;
  int          n_pass, n_fail, n_errors;

  ex_stage uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (req_i),
    .id_valid_i        (id_valid_i),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .wb_ready_i        (wb_ready_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .fwd_o             (fwd_o),
    .wb_o              (wb_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic bit branch_op(input ex_op_e op);
    return op == OP_BEQ || op == OP_BLT;
  endfunction

  // Result goes out on the forwarding port
  function automatic bit forwards_result(input ex_op_e op);
    return op inside {OP_ADD, OP_SUB, OP_SLT, OP_DOT8, OP_DOT16};
  endfunction

  // WB port value while the item sits in WB; GPR loads and SDOTs write
  function automatic rf_wr_t wb_expect(input ex_req_t r, input word_t v);
    rf_wr_t w;
    w = '0;
    if ((r.op == OP_LOAD && !r.spr_dst.en) || r.op inside {OP_SDOT8, OP_SDOT16}) begin
      w.we    = 1'b1;
      w.waddr = r.waddr;
      w.wdata = v;
    end
    return w;
  endfunction

  task automatic check_rf_wr(input rf_wr_t exp, input rf_wr_t act, input string what,
                             inout bit ok);
    if (exp.we ? (act !== exp) : (act.we !== 1'b0)) begin   // Only we matters without a write
      $display("Fail at %0t ns: %s expected we=%0b waddr=%0d wdata=%h, got %0b %0d %h",
               $time, what, exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata);
      n_errors++;
      ok = 1'b0;
    end
  endtask

  task automatic check_branch(input logic exp_dec, input word_t exp_tgt, input logic act_dec,
                              input word_t act_tgt, input string what, inout bit ok);
    if (act_dec !== exp_dec || act_tgt !== exp_tgt) begin
      $display("Fail at %0t ns: %s expected decision %0b target %h, got %0b %h",
               $time, what, exp_dec, exp_tgt, act_dec, act_tgt);
      n_errors++;
      ok = 1'b0;
    end
  endtask

  task automatic verify_handshake(input logic exp_rdy, input logic exp_vld, inout bit ok);
    if (ex_ready_o !== exp_rdy || ex_valid_o !== exp_vld) begin
      $display("Fail at %0t ns: handshake expected ready %0b valid %0b, got %0b %0b",
               $time, exp_rdy, exp_vld, ex_ready_o, ex_valid_o);
      n_errors++;
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input int k, input bit ok);
    $display("%-16s %s", tag_tab[k], ok ? "passed" : "FAILED");
    if (ok) n_pass++;
    else n_fail++;
  endtask

  // Drive at the falling edge and check 1 ns before the rising edge
  task automatic run_cycle(input bit valid, input int k, output bit accepted);
    ex_req_t  r;
    rf_wr_t   exp_fwd;
    wb_item_t item;
    logic     exp_rdy, exp_vld, exp_dec;
    bit       wb_rdy;
    r       = '0;
    exp_fwd = '0;
    exp_dec = 1'b0;
    if (valid) r = req_tab[k];
    @(negedge clk);
    rnd    = next_random(rnd);
    wb_rdy = (rnd[1:0] != 2'b00);
    if (valid && branch_op(r.op)) wb_rdy = 1'b0;   // Branches always see a WB stall
    req_i       = r;
    id_valid_i  = valid;
    wb_ready_i  = wb_rdy;
    lsu_rdata_i = (wb_q.size() != 0) ? wb_q[0].ldata : 32'h0;
    #(CLK_PERIOD / 2 - 1);
    if (wb_q.size() != 0) check_rf_wr(wb_q[0].exp, wb_o, "wb_o", front_ok);
    else check_rf_wr('0, wb_o, "wb_o idle", front_ok);
    exp_rdy  = wb_rdy | (valid & branch_op(r.op));
    exp_vld  = valid & !branch_op(r.op) & (r.op != OP_NOP) & wb_rdy;
    accepted = valid & exp_rdy;
    verify_handshake(exp_rdy, exp_vld, req_ok);
    if (accepted && forwards_result(r.op)) begin
      exp_fwd.we    = 1'b1;
      exp_fwd.waddr = r.waddr;
      exp_fwd.wdata = exp_tab[k];
    end
    check_rf_wr(exp_fwd, fwd_o, "fwd_o", req_ok);
    if (valid && branch_op(r.op)) exp_dec = exp_tab[k][0];
    check_branch(exp_dec, r.operand_c, branch_decision_o, jump_target_o, "branch", req_ok);
    // Retirement first, then the new item takes the slot
    if (wb_rdy && wb_q.size() != 0) begin
      item = wb_q.pop_front();
      if (item.finishes) report_test(item.test, front_ok);
    end
    if (accepted && exp_vld) begin
      item.test     = k;
      item.finishes = r.op inside {OP_LOAD, OP_SDOT8, OP_SDOT16};
      item.exp      = wb_expect(r, exp_tab[k]);
      item.ldata    = ldata_tab[k];
      wb_q.push_back(item);
      front_ok = req_ok;
      if (!item.finishes) report_test(k, req_ok);
    end else if (accepted) begin
      report_test(k, req_ok);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus, main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus_loader
    int          fd;
    string       tok, rest;
    logic [31:0] fld [12];
    ex_req_t     r;
    bit          bad;
    bad = 1'b0;
    fd  = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      $display("Simulation failed");
      $finish;
    end else begin
      while (!$feof(fd) && !bad) begin
        if ($fscanf(fd, "%s", tok) == 1) begin
          if (tok.getc(0) == "#") begin
            void'($fgets(rest, fd));   // Column description
          end else begin
            for (int i = 0; i < 12; i++) begin
              if ($fscanf(fd, "%h", fld[i]) != 1) bad = 1'b1;
            end
            r.op             = ex_op_e'(fld[0][3:0]);
            r.operand_a      = fld[1];
            r.operand_b      = fld[2];
            r.operand_c      = fld[3];
            r.waddr          = fld[4][REG_ADDR_W-1:0];
            r.spr_dst.en     = fld[5][0];
            r.spr_dst.is_act = fld[6][0];
            r.spr_dst.idx    = fld[7][SPR_IDX_W-1:0];
            r.w_idx          = fld[8][SPR_IDX_W-1:0];
            r.a_idx          = fld[9][SPR_IDX_W-1:0];
            req_tab.push_back(r);
            ldata_tab.push_back(fld[10]);
            exp_tab.push_back(fld[11]);
            tag_tab.push_back(tok);
          end
        end
      end
      $fclose(fd);
      if (bad || req_tab.size() == 0) begin
        $display("The stimulus file is malformed or holds no tests");
        $display("Simulation failed");
        $finish;
      end else begin
        stim_loaded = 1'b1;
      end
    end
  end

  initial begin : main_sequence
    bit dummy;
    rst_n       = 1'b0;
    req_i       = '0;
    id_valid_i  = 1'b0;
    wb_ready_i  = 1'b0;
    lsu_rdata_i = '0;
    rst_ok      = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    check_rf_wr('0, fwd_o, "fwd_o in reset", rst_ok);
    check_rf_wr('0, wb_o, "wb_o in reset", rst_ok);
    verify_handshake(1'b0, 1'b0, rst_ok);
    check_branch(1'b0, '0, branch_decision_o, jump_target_o, "branch in reset", rst_ok);
    $display("%-16s %s", "reset", rst_ok ? "passed" : "FAILED");
    @(negedge clk);
    rst_n = 1'b1;
    wait (stim_loaded);
    for (int k = 0; k < req_tab.size(); k++) begin
      rnd = next_random(rnd);
      while (rnd[2:0] == 3'd0) begin   // Idle gap before the next instruction
        run_cycle(1'b0, 0, dummy);
        rnd = next_random(rnd);
      end
      req_ok = 1'b1;
      dummy  = 1'b0;
      while (!dummy) run_cycle(1'b1, k, dummy);
    end
    while (wb_q.size() != 0) run_cycle(1'b0, 0, dummy);   // Drain WB
    $display("Tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, n_errors);
    if (n_errors == 0 && n_fail == 0 && n_pass == req_tab.size()) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // About 30 cycles per test plus reset
  initial begin : watchdog
    wait (stim_loaded);
    #((req_tab.size() * 30 + RST_CYCLES) * CLK_PERIOD);
    $display("Timeout: the tests did not finish in the allotted time");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- verif/ex_stimulus.txt
# tag op operand_a operand_b operand_c waddr spr_en spr_act spr_idx w_idx a_idx ldata expected
# All fields hex; expected is fwd_o.wdata, branch decision or wb_o.wdata, 0 where nothing is written
add_basic    1 00000005 00000003 00000000 01 0 0 0 0 0 00000000 00000008
add_wrap     1 ffffffff 00000002 00000000 02 0 0 0 0 0 00000000 00000001
add_ovf      1 7fffffff 00000001 00000000 03 0 0 0 0 0 00000000 80000000
sub_basic    2 0000000a 00000003 00000000 04 0 0 0 0 0 00000000 00000007
sub_neg      2 00000003 0000000a 00000000 05 0 0 0 0 0 00000000 fffffff9
slt_true     3 fffffffe 00000001 00000000 06 0 0 0 0 0 00000000 00000001
slt_false    3 00000001 fffffffe 00000000 07 0 0 0 0 0 00000000 00000000
beq_taken    4 12345678 12345678 00000100 00 0 0 0 0 0 00000000 00000001
beq_not      4 12345678 12345679 00000200 00 0 0 0 0 0 00000000 00000000
blt_taken    5 80000000 00000001 00000300 00 0 0 0 0 0 00000000 00000001
blt_not      5 00000001 80000000 00000400 00 0 0 0 0 0 00000000 00000000
blt_equal    5 00000005 00000005 00000500 00 0 0 0 0 0 00000000 00000000
dot8_pos     6 01020304 01010101 00000000 09 0 0 0 0 0 00000000 0000000a
dot8_neg     6 ff020380 02ff0102 00000010 0a 0 0 0 0 0 00000000 ffffff0f
dot8_min     6 80808080 80808080 00000000 0b 0 0 0 0 0 00000000 00010000
dot8_wrap    6 7f7f7f7f 7f7f7f7f fffff000 0c 0 0 0 0 0 00000000 0000ec04
dot16_pos    7 00020003 00040005 00000001 0d 0 0 0 0 0 00000000 00000018
dot16_neg    7 ffff8000 00038000 00000000 0e 0 0 0 0 0 00000000 3ffffffd
dot16_wrap   7 7fff7fff 7fff7fff 80000000 0f 0 0 0 0 0 00000000 fffe0002
nop_bubble   0 00000000 00000000 00000000 00 0 0 0 0 0 00000000 00000000
ld_gpr_a     8 00000000 00000000 00000000 10 0 0 0 0 0 cafef00d cafef00d
ld_gpr_b     8 00000000 00000000 00000000 11 0 0 0 0 0 00000042 00000042
ld_w0        8 00000000 00000000 00000000 00 1 0 0 0 0 01020304 00000000
ld_w1        8 00000000 00000000 00000000 00 1 0 1 0 0 fffefdfc 00000000
ld_a0        8 00000000 00000000 00000000 00 1 1 0 0 0 02020202 00000000
ld_a1        8 00000000 00000000 00000000 00 1 1 1 0 0 0001ffff 00000000
add_spr_flag 1 00000010 00000020 00000000 12 1 0 0 0 0 deadbeef 00000030
sdot8_w0a0   9 00000000 00000000 00000000 13 0 0 0 0 0 00000000 00000014
sdot8_w1a0   9 00000000 00000000 00000100 14 0 0 0 1 0 00000000 000000ec
sdot16_w0a1  a 00000000 00000000 00000000 15 0 0 0 0 1 00000000 fffffdfe
sdot16_w1a1  a 00000000 00000000 00000010 16 0 0 0 1 1 00000000 00000212
sdot8_ld_w2  9 00000000 00000000 00000000 17 1 0 2 0 0 7f7f7f7f 00000014
ld_gpr_c     8 00000000 00000000 00000000 18 0 0 0 0 0 0badc0de 0badc0de
sub_sep      2 00000100 00000001 00000000 19 0 0 0 0 0 00000000 000000ff
sdot8_w2a0   9 00000000 00000000 00000000 1a 0 0 0 2 0 00000000 000003f8
ld_w3        8 00000000 00000000 00000000 00 1 0 3 0 0 00010002 00000000
ld_a1_new    8 00000000 00000000 00000000 00 1 1 1 0 0 00030004 00000000
add_sep      1 00000001 00000001 00000000 1b 0 0 0 0 0 00000000 00000002
slt_sep      3 80000000 00000000 00000000 1c 0 0 0 0 0 00000000 00000001
sdot16_w3a1  a 00000000 00000000 00000005 1d 0 0 0 3 1 00000000 00000010
beq_last     4 00000000 00000000 00000abc 00 0 0 0 0 0 00000000 00000001
add_last     1 00000100 00000200 00000000 1e 0 0 0 0 0 00000000 00000300

//--- tb.f
hdl/ex_op_pkg.sv
hdl/ex_port_pkg.sv
hdl/ex_alu.sv
hdl/ex_dot_unit.sv
hdl/ex_spr_file.sv
hdl/ex_fwd_ctrl.sv
hdl/ex_wb_reg.sv
hdl/ex_stage.sv
verif/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  # RTL in compile order, packages first
  - hdl/ex_op_pkg.sv
  - hdl/ex_port_pkg.sv
  - hdl/ex_alu.sv
  - hdl/ex_dot_unit.sv
  - hdl/ex_spr_file.sv
  - hdl/ex_fwd_ctrl.sv
  - hdl/ex_wb_reg.sv
  - hdl/ex_stage.sv

  # Testbench, top module tb_ex_stage
  - target: test
    files:
      - verif/tb_ex_stage.sv
